//--- filelist.f
+incdir+source
source/avm_pkg.sv
source/vid_pkg.sv
source/disp_ctrl.sv
source/disp_fifo.sv
source/vga_timing.sv
source/disp_top.sv
dv/tb_avm_mem.sv
dv/tb_disp_top.sv

//--- dv/tb_disp_top.sv
/*
 * testbench for the frame buffer display path
 * small raster, Avalon memory model, pixel checker and directed tests
 */
`timescale 1ns/1ps
`include "disp_config.svh"

module tb_disp_top;
    import avm_pkg::*;
    import vid_pkg::*;

    localparam int  H_ACT = 32;
    localparam int  V_ACT = 4;
    localparam int  H_BLK = 24;
    localparam int  V_BLK = 12;
    localparam int  H_TOT = H_ACT + H_BLK;
    localparam int  V_TOT = V_ACT + V_BLK;
    localparam int  FRAME_CYC = H_TOT * V_TOT;
    localparam int  FRAME_BYTES = H_ACT * V_ACT * 2;
    localparam int  NUM_TESTS = 6;
    // sync pulses are cut off where the blanking interval ends
    localparam int  HS_W = (`DISP_H_FP + `DISP_H_SYNC > H_BLK) ? H_BLK - `DISP_H_FP : `DISP_H_SYNC;
    localparam int  VS_W = (`DISP_V_FP + `DISP_V_SYNC > V_BLK) ? V_BLK - `DISP_V_FP : `DISP_V_SYNC;
    localparam time PERIOD = 100ns;
    localparam time DRV = 10ns;
    localparam logic [`DISP_ADDR_W-1:0] BASE_A = 26'h000_1000;
    localparam logic [`DISP_ADDR_W-1:0] BASE_B = 26'h0a1_ffc0;  // pixel data wraps at 16 bits

    typedef struct packed {
        int cycles;
        int cmds;       // accepted read commands
        int hs_rises;
        int hs_high;
        int vs_high;
    } frame_stats_t;

    logic                    CLK;
    logic                    RST;
    logic                    disp_on;
    logic                    gaps_on;
    logic                    pix_check;
    logic [`DISP_ADDR_W-1:0] disp_addr;
    avm_req_t                avm_req;
    avm_rsp_t                avm_rsp;
    vid_out_t                vid;
    logic                    underrun;
    int                      errors = 0;
    int                      frames_checked = 0;
    int                      pix_checked = 0;
    logic                    frame_valid;
    logic                    vs_q;
    int                      pix_idx;
    logic [`DISP_ADDR_W-1:0] frame_base;
    pixel_t                  exp_pix;

    disp_top #(
        .H_ACTIVE (H_ACT),
        .H_BLANK  (H_BLK),
        .V_ACTIVE (V_ACT),
        .V_BLANK  (V_BLK)
    ) i_dut (
        .CLK       (CLK),
        .RST       (RST),
        .disp_on   (disp_on),
        .disp_addr (disp_addr),
        .avm_req   (avm_req),
        .avm_rsp   (avm_rsp),
        .vid       (vid),
        .underrun  (underrun)
    );

    tb_avm_mem i_mem (
        .CLK     (CLK),
        .RST     (RST),
        .gaps_on (gaps_on),
        .avm_req (avm_req),
        .avm_rsp (avm_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(PERIOD * FRAME_CYC * 8 * NUM_TESTS);
        $display("timeout: the tests did not finish in the allowed time");
        $display("errors %0d, frames checked %0d", errors, frames_checked);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("error: %s expected %h got %h at %0t", name, exp, got, $time);
    endtask

    // pixel checker, a frame's base is disp_addr as seen at the vsync before it
    always @(negedge CLK) begin
        if (RST) begin
            frame_valid = 1'b0;
            vs_q        = 1'b0;
            pix_idx     = 0;
        end else begin
            if (vid.vsync && !vs_q) begin
                if (frame_valid) begin
                    if (pix_idx != H_ACT * V_ACT) begin
                        report_mismatch("pixels per frame", H_ACT * V_ACT, pix_idx);
                    end
                    frames_checked++;
                end
                frame_valid = pix_check;
                frame_base  = disp_addr;
                pix_idx     = 0;
            end
            if (vid.de) begin
                exp_pix = 16'((frame_base >> 1) + pix_idx);
                if (frame_valid) begin
                    if (vid.pix !== exp_pix) report_mismatch("vid.pix", exp_pix, vid.pix);
                    pix_checked++;
                end
                pix_idx++;
            end else if (vid.pix !== '0) begin
                report_mismatch("vid.pix", 0, vid.pix);     // blanking must be black
            end
            vs_q = vid.vsync;
        end
    end

    task automatic reset_dut(input logic on, input logic [`DISP_ADDR_W-1:0] addr,
                             input logic gaps, input logic check);
        @(posedge CLK);
        #DRV;
        RST       = 1'b1;
        disp_on   = on;
        disp_addr = addr;
        gaps_on   = gaps;
        pix_check = check;
        repeat (3) @(posedge CLK);
        #DRV RST = 1'b0;
    endtask

    task automatic wait_vsync_rise();
        logic prev;
        prev = vid.vsync;
        @(negedge CLK);
        while (!(vid.vsync && !prev)) begin
            prev = vid.vsync;
            @(negedge CLK);
        end
    endtask

    task automatic wait_de();
        @(negedge CLK);
        while (!vid.de) @(negedge CLK);
    endtask

    // called on a vsync rise, returns on the next one
    task automatic measure_frame(output frame_stats_t st);
        logic vs_last;
        logic hs_last;
        st      = '0;
        vs_last = 1'b0;
        hs_last = 1'b0;
        do begin
            st.cycles++;
            if (avm_req.read && !avm_rsp.waitrequest) st.cmds++;
            if (vid.hsync && !hs_last) st.hs_rises++;
            if (vid.hsync) st.hs_high++;
            if (vid.vsync) st.vs_high++;
            vs_last = vid.vsync;
            hs_last = vid.hsync;
            @(negedge CLK);
        end while (!(vid.vsync && !vs_last));
    endtask

    task automatic test_reset();
        reset_dut(1'b1, BASE_A, 1'b0, 1'b0);
        if (avm_req.read !== 1'b0) report_mismatch("avm_req.read", 0, avm_req.read);
        if (vid.de !== 1'b0) report_mismatch("vid.de", 0, vid.de);
        if (vid.hsync !== 1'b0) report_mismatch("vid.hsync", 0, vid.hsync);
        if (vid.vsync !== 1'b0) report_mismatch("vid.vsync", 0, vid.vsync);
        if (underrun !== 1'b0) report_mismatch("underrun", 0, underrun);
    endtask

    task automatic test_basic();
        int first;
        reset_dut(1'b1, BASE_A, 1'b0, 1'b1);
        first = pix_checked;
        repeat (4) wait_vsync_rise();   // frame 0 only primes the FIFO
        @(negedge CLK);
        if (pix_checked - first != 3 * H_ACT * V_ACT) begin
            report_mismatch("pixels checked", 3 * H_ACT * V_ACT, pix_checked - first);
        end
    endtask

    task automatic test_stalls();
        int           first;
        frame_stats_t st;
        reset_dut(1'b1, BASE_B, 1'b1, 1'b1);
        first = pix_checked;
        wait_vsync_rise();
        repeat (3) begin
            measure_frame(st);
            if (st.cmds != FRAME_BYTES / `DISP_BURST_BYTES) begin
                report_mismatch("bursts per frame", FRAME_BYTES / `DISP_BURST_BYTES, st.cmds);
            end
        end
        @(negedge CLK);
        if (pix_checked - first != 3 * H_ACT * V_ACT) begin
            report_mismatch("pixels checked", 3 * H_ACT * V_ACT, pix_checked - first);
        end
    endtask

    task automatic test_display_off();
        frame_stats_t st;
        reset_dut(1'b0, BASE_A, 1'b0, 1'b0);
        if (underrun !== 1'b0) report_mismatch("underrun", 0, underrun);
        wait_de();
        @(negedge CLK);
        if (underrun !== 1'b1) report_mismatch("underrun", 1, underrun);
        wait_vsync_rise();
        measure_frame(st);
        if (st.cmds != 0) report_mismatch("read commands", 0, st.cmds);
    endtask

    task automatic test_base_change();
        int first;
        reset_dut(1'b1, BASE_A, 1'b0, 1'b1);
        first = pix_checked;
        wait_vsync_rise();
        wait_de();
        @(posedge CLK);
        #DRV disp_addr = BASE_B;    // mid-line, frame 1 keeps the old base
        repeat (2) wait_vsync_rise();
        @(negedge CLK);
        if (pix_checked - first != 2 * H_ACT * V_ACT) begin
            report_mismatch("pixels checked", 2 * H_ACT * V_ACT, pix_checked - first);
        end
    endtask

    task automatic test_sync_counts();
        frame_stats_t st;
        reset_dut(1'b1, BASE_A, 1'b0, 1'b0);
        wait_vsync_rise();
        repeat (2) begin
            measure_frame(st);
            if (st.cycles != FRAME_CYC) report_mismatch("cycles per vsync", FRAME_CYC, st.cycles);
            if (st.hs_rises != V_TOT) report_mismatch("hsync rises", V_TOT, st.hs_rises);
            if (st.hs_high != V_TOT * HS_W) report_mismatch("hsync high", V_TOT * HS_W, st.hs_high);
            if (st.vs_high != VS_W * H_TOT) report_mismatch("vsync high", VS_W * H_TOT, st.vs_high);
        end
    endtask

    initial begin
        RST       = 1'b1;
        disp_on   = 1'b0;
        disp_addr = '0;
        gaps_on   = 1'b0;
        pix_check = 1'b0;
        test_reset();
        test_basic();
        test_stalls();
        test_display_off();
        test_base_change();
        test_sync_counts();
        $display("errors %0d, frames checked %0d", errors, frames_checked);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- dv/tb_avm_mem.sv
/*
 * Avalon-MM burst read memory model
 * every beat returns its own byte address halved, with optional
 * pseudo-random waitrequest and readdatavalid gaps
 */
`timescale 1ns/1ps
`include "disp_config.svh"

module tb_avm_mem (
    input  logic              CLK,
    input  logic              RST,
    input  logic              gaps_on,
    input  avm_pkg::avm_req_t avm_req,
    output avm_pkg::avm_rsp_t avm_rsp
);
    logic [31:0]             rng;
    logic [31:0]             rnd;
    logic [`DISP_ADDR_W-1:0] bursts [$];    // accepted read commands
    logic [`DISP_ADDR_W-1:0] beat_addr;
    int                      beats_left;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    always @(posedge CLK) begin
        if (RST) begin
            rng        <= 32'h5f25_9514;
            avm_rsp    <= '0;
            beats_left = 0;
            bursts.delete();
        end else begin
            rnd = xorshift(rng);
            rng <= rnd;
            avm_rsp.waitrequest   <= gaps_on && (rnd[1:0] == 2'b00);  // about one in four
            avm_rsp.readdatavalid <= 1'b0;
            avm_rsp.readdata      <= '0;
            if (beats_left == 0 && bursts.size() != 0) begin
                beat_addr  = bursts.pop_front();
                beats_left = `DISP_BURST_LEN;
            end
            // a gap holds the beat back by one cycle
            if (beats_left != 0 && !(gaps_on && rnd[3:2] == 2'b00)) begin
                avm_rsp.readdatavalid <= 1'b1;
                avm_rsp.readdata      <= beat_addr[16:1];
                beat_addr  = beat_addr + 2;
                beats_left = beats_left - 1;
            end
            if (avm_req.read && !avm_rsp.waitrequest) begin
                bursts.push_back(avm_req.address);
            end
        end
    end

endmodule

//--- source/disp_top.sv
/*
 * frame buffer display path
 * burst fetch master, pixel FIFO and raster timing generator
 */
`timescale 1ns/1ps
`include "disp_config.svh"

module disp_top #(
    parameter int H_ACTIVE = `DISP_H_ACTIVE,
    parameter int H_BLANK  = `DISP_H_BLANK,
    parameter int V_ACTIVE = `DISP_V_ACTIVE,
    parameter int V_BLANK  = `DISP_V_BLANK
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    disp_on,
    input  logic [`DISP_ADDR_W-1:0] disp_addr,
    output avm_pkg::avm_req_t       avm_req,
    input  avm_pkg::avm_rsp_t       avm_rsp,
    output vid_pkg::vid_out_t       vid,
    output logic                    underrun
);
    import vid_pkg::*;

    logic   vblank;
    logic   fifo_ready;
    logic   push;
    pixel_t push_data;
    logic   pop;
    pixel_t head;

    disp_ctrl #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) i_ctrl (
        .CLK        (CLK),
        .RST        (RST),
        .disp_on    (disp_on),
        .disp_addr  (disp_addr),
        .vblank     (vblank),
        .fifo_ready (fifo_ready),
        .avm_req    (avm_req),
        .avm_rsp    (avm_rsp),
        .push       (push),
        .push_data  (push_data)
    );

    disp_fifo i_fifo (
        .CLK        (CLK),
        .RST        (RST),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .head       (head),
        .fifo_ready (fifo_ready),
        .underrun   (underrun)
    );

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_BLANK  (H_BLANK),
        .V_ACTIVE (V_ACTIVE),
        .V_BLANK  (V_BLANK)
    ) i_timing (
        .CLK    (CLK),
        .RST    (RST),
        .head   (head),
        .pop    (pop),
        .vblank (vblank),
        .vid    (vid)
    );

endmodule

//--- source/vga_timing.sv
/*
 * raster timing generator
 * horizontal and vertical counters, registered sync and data enable,
 * pops one FIFO pixel per active cycle
 */
`timescale 1ns/1ps
`include "disp_config.svh"

module vga_timing #(
    parameter int H_ACTIVE = `DISP_H_ACTIVE,
    parameter int H_BLANK  = `DISP_H_BLANK,
    parameter int V_ACTIVE = `DISP_V_ACTIVE,
    parameter int V_BLANK  = `DISP_V_BLANK
) (
    input  logic              CLK,
    input  logic              RST,
    input  vid_pkg::pixel_t   head,
    output logic              pop,
    output logic              vblank,
    output vid_pkg::vid_out_t vid
);
    localparam int H_TOTAL  = H_ACTIVE + H_BLANK;
    localparam int V_TOTAL  = V_ACTIVE + V_BLANK;
    localparam int HW       = $clog2(H_TOTAL);
    localparam int VW       = $clog2(V_TOTAL);
    localparam int HS_START = H_ACTIVE + `DISP_H_FP;
    localparam int HS_END   = HS_START + `DISP_H_SYNC;
    localparam int VS_START = V_ACTIVE + `DISP_V_FP;
    localparam int VS_END   = VS_START + `DISP_V_SYNC;

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          h_last;
    logic          v_last;
    logic          de_c;
    logic          hsync_c;
    logic          vsync_c;
    logic          de_q;
    logic          hsync_q;
    logic          vsync_q;

    assign h_last = (h_cnt == HW'(H_TOTAL - 1));
    assign v_last = (v_cnt == VW'(V_TOTAL - 1));

    // reset starts on the first active line
    always_ff @(posedge CLK) begin
        if (RST) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
        end
    end

    assign de_c    = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign hsync_c = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign vsync_c = (v_cnt >= VS_START) && (v_cnt < VS_END);

    always_ff @(posedge CLK) begin
        if (RST) begin
            de_q    <= 1'b0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            vblank  <= 1'b0;
        end else begin
            de_q    <= de_c;
            hsync_q <= hsync_c;
            vsync_q <= vsync_c;
            vblank  <= (v_cnt >= V_ACTIVE);     // all blanking lines
        end
    end

    assign pop = de_q;  // head leaves on the cycle it is shown

    always_comb begin
        vid.hsync = hsync_q;
        vid.vsync = vsync_q;
        vid.de    = de_q;
        vid.pix   = de_q ? head : '0;
    end

endmodule

//--- source/disp_fifo.sv
/*
 * pixel FIFO
 * show-ahead circular buffer between the fetch master and the raster,
 * ready level keeps room for a whole burst, sticky underrun flag
 */
`timescale 1ns/1ps
`include "disp_config.svh"

module disp_fifo (
    input  logic            CLK,
    input  logic            RST,
    input  logic            push,
    input  vid_pkg::pixel_t push_data,
    input  logic            pop,
    output vid_pkg::pixel_t head,
    output logic            fifo_ready,
    output logic            underrun
);
    import vid_pkg::*;

    localparam int DEPTH = `DISP_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);
    localparam int UW    = CW + 1;
    localparam int BW    = $clog2(`DISP_BURST_LEN);

    localparam logic [UW-1:0] READY_LIMIT = UW'(DEPTH - `DISP_BURST_LEN);

    pixel_t        mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [BW-1:0] beat_cnt;
    logic [CW-1:0] reserved;
    logic [UW-1:0] used;
    logic          empty;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;     // wraps at DEPTH
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // position inside the current burst, back to zero after beat 16
    always_ff @(posedge CLK) begin
        if (RST) begin
            beat_cnt <= '0;
        end else if (push) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // beats of the open burst still on their way
    assign reserved = (beat_cnt == '0) ? '0 : CW'(`DISP_BURST_LEN) - CW'(beat_cnt);
    assign used       = {1'b0, count} + {1'b0, reserved};
    assign fifo_ready = (used <= READY_LIMIT);

    always_ff @(posedge CLK) begin
        if (RST) begin
            underrun <= 1'b0;
        end else if (pop && empty) begin
            underrun <= 1'b1;   // held until reset
        end
    end

    assign head = mem[rd_ptr];

endmodule

//--- source/disp_ctrl.sv
/*
 * display fetch controller
 * Avalon-MM burst read master, walks one frame of video memory
 * per vertical blanking edge and pushes the beats into the pixel FIFO
 */
`timescale 1ns/1ps
`include "disp_config.svh"

module disp_ctrl #(
    parameter int H_ACTIVE = `DISP_H_ACTIVE,
    parameter int V_ACTIVE = `DISP_V_ACTIVE
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    disp_on,
    input  logic [`DISP_ADDR_W-1:0] disp_addr,
    input  logic                    vblank,
    input  logic                    fifo_ready,
    output avm_pkg::avm_req_t       avm_req,
    input  avm_pkg::avm_rsp_t       avm_rsp,
    output logic                    push,
    output vid_pkg::pixel_t         push_data
);
    import vid_pkg::*;

    localparam int AW = `DISP_ADDR_W;
    localparam int BW = $clog2(`DISP_BURST_LEN);
    localparam int FRAME_SIZE = H_ACTIVE * V_ACTIVE * (`DISP_DATA_W / 8);

    localparam logic [AW-1:0] FRAME_BYTES = AW'(FRAME_SIZE);
    localparam logic [AW-1:0] BURST_STEP  = AW'(`DISP_BURST_BYTES);
    localparam logic [BW-1:0] LAST_BEAT   = BW'(`DISP_BURST_LEN - 1);

    fetch_state_e  state;
    fetch_state_e  state_nxt;
    logic [1:0]    vblank_q;
    logic          start;
    logic [AW-1:0] base_q;
    logic [AW-1:0] addr_cnt;
    logic [BW-1:0] beat_cnt;
    logic          cmd_accept;
    logic          last_beat;
    logic          frame_end;

    // vblank rising edge, one cycle after it is first sampled
    always_ff @(posedge CLK) begin
        if (RST) begin
            vblank_q <= 2'b00;
        end else begin
            vblank_q <= {vblank_q[0], vblank};
        end
    end

    assign start = disp_on && (vblank_q == 2'b01);

    assign cmd_accept = (state == SETADDR) && !avm_rsp.waitrequest;
    assign last_beat  = avm_rsp.readdatavalid && (beat_cnt == LAST_BEAT);
    assign frame_end  = (addr_cnt == FRAME_BYTES);

    // base is sampled once per frame, so a change lands on the next fetch
    always_ff @(posedge CLK) begin
        if (state == HALT && start) begin
            base_q <= disp_addr;
        end
    end

    // byte offset into the frame
    always_ff @(posedge CLK) begin
        if (RST) begin
            addr_cnt <= '0;
        end else if (state == HALT && start) begin
            addr_cnt <= '0;
        end else if (cmd_accept) begin
            addr_cnt <= addr_cnt + BURST_STEP;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            beat_cnt <= '0;
        end else if (state == SETADDR) begin
            beat_cnt <= '0;
        end else if (avm_rsp.readdatavalid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= HALT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            HALT: begin
                if (start) state_nxt = SETADDR;
            end
            SETADDR: begin
                if (!avm_rsp.waitrequest) state_nxt = READING;
            end
            READING: begin
                if (last_beat) begin
                    if (frame_end) begin
                        state_nxt = HALT;       // whole frame fetched
                    end else if (!fifo_ready) begin
                        state_nxt = WAITING;
                    end else begin
                        state_nxt = SETADDR;
                    end
                end
            end
            WAITING: begin
                if (fifo_ready) state_nxt = SETADDR;
            end
            default: state_nxt = HALT;
        endcase
    end

    assign avm_req.address = base_q + addr_cnt;
    assign avm_req.read    = (state == SETADDR);

    // every returned beat goes straight to the FIFO
    assign push      = avm_rsp.readdatavalid;
    assign push_data = avm_rsp.readdata;

endmodule

//--- source/vid_pkg.sv
/*
 * video path types
 * fetch FSM states, RGB565 pixel and the raster output bundle
 */
`include "disp_config.svh"

package vid_pkg;

    typedef enum logic [1:0] {
        HALT,       // idle until next start edge
        SETADDR,    // read command pending on the bus
        READING,    // collecting the 16 burst beats
        WAITING     // FIFO has no room for another burst
    } fetch_state_e;

    // r[15:11] g[10:5] b[4:0]
    typedef logic [`DISP_DATA_W-1:0] pixel_t;

    typedef struct packed {
        logic   hsync;  // active high
        logic   vsync;  // active high
        logic   de;
        pixel_t pix;    // zero outside active area
    } vid_out_t;

endpackage

//--- source/avm_pkg.sv
/*
 * Avalon-MM read port types
 * request from the burst read master, response from the video memory
 */
`include "disp_config.svh"

package avm_pkg;

    // master side, read command with byte address
    typedef struct packed {
        logic [`DISP_ADDR_W-1:0] address;
        logic                    read;
    } avm_req_t;

    // slave side, stall and returned beats
    typedef struct packed {
        logic                    waitrequest;
        logic                    readdatavalid;
        logic [`DISP_DATA_W-1:0] readdata;
    } avm_rsp_t;

endpackage

//--- source/disp_config.svh
/*
 * display path configuration
 * bus widths, burst geometry, pixel FIFO depth and raster timing
 */
`ifndef DISP_CONFIG_SVH
`define DISP_CONFIG_SVH

// Avalon-MM read port
`define DISP_ADDR_W       26     // byte address
`define DISP_DATA_W       16     // one RGB565 pixel per beat

// fixed burst geometry of the video memory
`define DISP_BURST_LEN    16
`define DISP_BURST_BYTES  32     // 16 beats of 2 bytes

`define DISP_FIFO_DEPTH   64     // power of two

// raster geometry in pixels and lines
`define DISP_H_ACTIVE     640
`define DISP_V_ACTIVE     480
`define DISP_H_BLANK      160
`define DISP_V_BLANK      45

// sync pulses, measured from the end of active video
`define DISP_H_FP         16
`define DISP_H_SYNC       96
`define DISP_V_FP         10
`define DISP_V_SYNC       2

`endif
